//--- tb.f
rtl/cachePkg.sv
rtl/tagStore.sv
rtl/dataStore.sv
rtl/cacheCtrl.sv
rtl/cacheTop.sv
tests/tbMemory.sv
tests/cacheTb.sv

//--- tests/cacheTb.sv
// cache testbench
// random loads and stores over a small address pool, checked against
// a model of the memory image and of the tag, valid, dirty and rr state

`timescale 1ns/1ps

module cacheTb;
	import cachePkg::*;

	localparam int numRandom      = 300;
	localparam int numReqs        = numRandom + 64;     // random plus readback
	localparam int watchdogCycles = numReqs * 40 + 10;  // worst miss plus reset

	logic                clk = 1'b0;
	logic                rstn;
	logic                valid;
	cpuReqT              req;
	logic                dataOK;
	logic [wordBits-1:0] loadData;
	logic                loadReq;
	logic [addrBits-1:0] loadAddr;
	logic                loadReady;
	refillT              ret;
	logic                storeReq;
	logic [addrBits-1:0] storeAddr;
	lineT                storeData;
	logic                storeReady;

	// model state
	logic [tagBits-1:0]  mTag [numWays][numSets];
	logic [numSets-1:0]  mValid [numWays];
	logic [numSets-1:0]  mDirty [numWays];
	logic [numSets-1:0]  mRr;
	logic [wordBits-1:0] image [4096];  // cpu view, addr[13:2]
	logic [4095:0]       imageSet;

	// tags differ in bits 1:0 so the 13:2 window never aliases
	logic [tagBits-1:0]   tagPool [4] = '{20'h12340, 20'h0abc1, 20'hfed02, 20'h70003};
	logic [indexBits-1:0] setPool [4] = '{8'h03, 8'h47, 8'h9c, 8'hf1};

	integer seed = 32'h7b3c63b9;
	int     errCount = 0;
	int     errMark = 0;  // errors at start of test
	int     reqCount = 0;
	int     beatCount = 0; // refill words taken by the cache

	always #4 clk = ~clk;

	always @(posedge clk) begin
		if (ret.valid) begin
			beatCount++;
		end
	end

	cacheTop dut (
		.clk            (clk),
		.rstn           (rstn),
		.i_Valid        (valid),
		.i_Req          (req),
		.o_DataOK       (dataOK),
		.o_LoadData     (loadData),
		.o_LoadRequire  (loadReq),
		.o_LoadAddr     (loadAddr),
		.i_LoadReady    (loadReady),
		.i_Return       (ret),
		.o_StoreRequire (storeReq),
		.o_StoreAddr    (storeAddr),
		.o_StoreData    (storeData),
		.i_StoreReady   (storeReady)
	);

	tbMemory #(.seedInit(32'h7b3c63b9)) mem (
		.clk            (clk),
		.rstn           (rstn),
		.i_LoadRequire  (loadReq),
		.i_LoadAddr     (loadAddr),
		.o_LoadReady    (loadReady),
		.o_Return       (ret),
		.i_StoreRequire (storeReq),
		.i_StoreAddr    (storeAddr),
		.i_StoreData    (storeData),
		.o_StoreReady   (storeReady)
	);

	// same fill pattern as the bus memory
	function automatic logic [31:0] imageWord(input logic [31:0] a);
		return imageSet[a[13:2]] ? image[a[13:2]] : a ^ {a[15:0], a[31:16]} ^ 32'h9e3779b9;
	endfunction

	task automatic valueError(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		$display("** Error: %s = %0h, expected %0h at %0t ns", name, got, exp, $time);
		errCount++;
	endtask

	task automatic reportFail(input string what);
		$display("Failure at %0t ns: %s", $time, what);
		errCount++;
	endtask

	task automatic endTest(input string name);
		$display("test %s finished with %0d errors", name, errCount - errMark);
		errMark = errCount;
	endtask

	// one cpu request, starting and ending on a falling edge in idle
	task automatic runRequest(input logic wr, input logic [31:0] addr,
		input logic [31:0] data);
		logic [indexBits-1:0] set;
		logic [tagBits-1:0]   tag;
		logic                 predHit;
		logic                 way;      // hit way, else victim way
		logic                 vDirty;
		logic                 sawLoad;
		logic                 sawStore;
		logic                 done;
		logic [31:0]          vAddr;
		lineT                 vLine;
		int                   cycles;
		int                   beatStart;
		int                   beats;
		set     = addr[11:4];
		tag     = addr[31:12];
		predHit = 1'b0;
		way     = mRr[set];            // rr unless a way is free
		if (!mValid[1][set]) way = 1'b1;
		if (!mValid[0][set]) way = 1'b0; // lowest invalid first
		for (int w = 0; w < numWays; w++) begin
			if (mValid[w][set] && mTag[w][set] == tag) begin
				predHit = 1'b1;
				way     = 1'(w);
			end
		end
		vDirty = !predHit && mValid[way][set] && mDirty[way][set];
		vAddr  = {mTag[way][set], set, 4'h0};
		for (int b = 0; b < wordsPerLine; b++) begin
			vLine[b] = vDirty ? imageWord(vAddr + 4 * b) : '0;
		end
		req.write     = wr;
		req.addr.raw  = addr;
		req.storeData = data;
		valid         = 1'b1;
		cycles        = 0;
		beatStart     = beatCount;
		sawLoad       = 1'b0;
		sawStore      = 1'b0;
		done          = 1'b0;
		while (!done) begin
			@(negedge clk);
			cycles++;
			if (storeReq) begin
				assert (vDirty && !sawLoad)
					else reportFail("writeback without a dirty victim, or after the fetch");
				assert (storeAddr === vAddr)
					else valueError("o_StoreAddr", storeAddr, vAddr);
				assert (storeData === vLine)
					else valueError("o_StoreData", storeData, vLine);
				sawStore = 1'b1;
			end
			if (loadReq) begin
				assert (!predHit && sawStore == vDirty)
					else reportFail("line fetch for a hit, or ahead of the writeback");
				assert (loadAddr === {addr[31:4], 4'h0})
					else valueError("o_LoadAddr", loadAddr, {addr[31:4], 4'h0});
				sawLoad = 1'b1;
			end
			done = dataOK;
		end
		beats = beatCount - beatStart;
		if (predHit) begin
			assert (cycles == 1)
				else reportFail($sformatf("hit took %0d cycles", cycles));
		end else begin
			assert (sawLoad && sawStore == vDirty)
				else reportFail("miss ended without its bus transfers");
			assert (beats == wordsPerLine)
				else reportFail($sformatf("miss answered after %0d refill words", beats));
		end
		if (!wr) begin
			assert (loadData === imageWord(addr))
				else valueError("o_LoadData", loadData, imageWord(addr));
		end
		valid = 1'b0;
		if (!predHit) begin
			mTag[way][set]   = tag;
			mValid[way][set] = 1'b1;
			mDirty[way][set] = 1'b0; // refilled line is clean
			mRr[set]         = ~mRr[set];
		end
		if (wr) begin
			mDirty[way][set]      = 1'b1;
			image[addr[13:2]]     = data;
			imageSet[addr[13:2]]  = 1'b1;
		end
		reqCount++;
		@(negedge clk); // controller back in idle
		assert (!dataOK) else reportFail("o_DataOK stayed high after its cycle");
	endtask

	initial begin
		logic [31:0] addr;
		logic        wr;
		rstn      = 1'b0;
		valid     = 1'b0;
		req       = '0;
		imageSet  = '0;
		mValid[0] = '0;
		mValid[1] = '0;
		mDirty[0] = '0;
		mDirty[1] = '0;
		mRr       = '0;
		repeat (10) @(negedge clk);
		rstn = 1'b1;
		repeat (4) begin
			@(negedge clk);
			assert (!dataOK && !loadReq && !storeReq)
				else reportFail("strobe active right after reset");
		end
		endTest("reset");
		for (int n = 0; n < numRandom; n++) begin
			addr = {tagPool[$random(seed) & 3], setPool[$random(seed) & 3],
				2'($random(seed)), 2'b00};
			wr   = ($random(seed) & 7) < 3; // about 3 in 8 are stores
			runRequest(wr, addr, $random(seed));
		end
		endTest("random");
		for (int t = 0; t < 4; t++) begin
			for (int s = 0; s < 4; s++) begin
				for (int w = 0; w < wordsPerLine; w++) begin
					runRequest(1'b0, {tagPool[t], setPool[s], 2'(w), 2'b00}, '0);
				end
			end
		end
		endTest("readback");
		$display("summary: %0d requests, %0d errors", reqCount, errCount);
		if (errCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the cache stopped answering",
			watchdogCycles);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- tests/tbMemory.sv
// bus memory model
// answers line fetches and victim writebacks after random delays;
// decodes address bits 13:2 only
// words never written read a fill pattern

`timescale 1ns/1ps

module tbMemory #(
	parameter int seedInit = 32'h7b3c63b9
) (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          i_LoadRequire,
	input  logic [cachePkg::addrBits-1:0] i_LoadAddr,
	output logic                          o_LoadReady,
	output cachePkg::refillT              o_Return,
	input  logic                          i_StoreRequire,
	input  logic [cachePkg::addrBits-1:0] i_StoreAddr,
	input  cachePkg::lineT                i_StoreData,
	output logic                          o_StoreReady
);
	import cachePkg::*;

	logic [wordBits-1:0] memData [4096]; // word window addr[13:2]
	logic [4095:0]       memWritten;     // word holds written data
	integer              seed = seedInit;
	logic [addrBits-1:0] lineAddr;       // line taken on ready

	// fill pattern over the whole address
	function automatic logic [31:0] backgroundWord(input logic [31:0] a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h9e3779b9;
	endfunction

	function automatic logic [31:0] memWord(input logic [31:0] a);
		return memWritten[a[13:2]] ? memData[a[13:2]] : backgroundWord(a);
	endfunction

	task automatic randomWait(input int mask);
		int n;
		n = $random(seed) & mask;
		repeat (n) @(negedge clk);
	endtask

	initial begin
		memWritten   = '0;
		o_LoadReady  = 1'b0;
		o_StoreReady = 1'b0;
		o_Return     = '0;
		forever begin
			@(negedge clk);
			if (rstn && i_StoreRequire) begin
				randomWait(3); // 0 to 3 cycles of back-pressure
				lineAddr = i_StoreAddr;
				for (int w = 0; w < wordsPerLine; w++) begin
					memData[lineAddr[13:2] + w]    = i_StoreData[w];
					memWritten[lineAddr[13:2] + w] = 1'b1;
				end
				o_StoreReady = 1'b1;
				@(negedge clk);
				o_StoreReady = 1'b0;
			end else if (rstn && i_LoadRequire) begin
				randomWait(3);
				lineAddr    = i_LoadAddr;
				o_LoadReady = 1'b1;
				@(negedge clk);
				o_LoadReady = 1'b0;
				for (int w = 0; w < wordsPerLine; w++) begin
					randomWait(1); // gap before each beat
					o_Return = {1'b1, wordSelBits'(w), memWord(lineAddr + 4 * w)};
					@(negedge clk);
					o_Return = '0; // each beat valid for one edge
				end
			end
		end
	end

endmodule

//--- rtl/cacheTop.sv
// data cache top
// two-way set-associative write-back cache between the cpu pipeline
// and the memory bus; controller plus tag and data stores

`timescale 1ns/1ps

module cacheTop (
	input  logic                         clk,
	input  logic                         rstn,
	input  logic                         i_Valid,
	input  cachePkg::cpuReqT             i_Req,
	output logic                         o_DataOK,
	output logic [cachePkg::wordBits-1:0] o_LoadData,
	output logic                         o_LoadRequire,  // line fetch
	output logic [cachePkg::addrBits-1:0] o_LoadAddr,
	input  logic                         i_LoadReady,
	input  cachePkg::refillT             i_Return,
	output logic                         o_StoreRequire, // victim writeback
	output logic [cachePkg::addrBits-1:0] o_StoreAddr,
	output cachePkg::lineT               o_StoreData,
	input  logic                         i_StoreReady
);
	import cachePkg::*;

	logic [indexBits-1:0]   readIndex;
	logic [tagBits-1:0]     lookupTag;
	logic                   way;
	logic [wordSelBits-1:0] wordSel;
	logic                   wordWrite;
	logic [wordBits-1:0]    writeWord;
	logic                   refillWrite;
	logic                   tagFill;
	logic                   hit;
	logic                   hitWay;
	logic                   victimWay;
	logic                   victimDirty;
	logic [tagBits-1:0]     victimTag;
	logic [wordBits-1:0]    readWord;
	lineT                   victimLine;

	cacheCtrl uCtrl (
		.clk            (clk),
		.rstn           (rstn),
		.i_Valid        (i_Valid),
		.i_Req          (i_Req),
		.i_Hit          (hit),
		.i_HitWay       (hitWay),
		.i_VictimWay    (victimWay),
		.i_VictimDirty  (victimDirty),
		.i_VictimTag    (victimTag),
		.i_ReadWord     (readWord),
		.i_VictimLine   (victimLine),
		.i_LoadReady    (i_LoadReady),
		.i_Return       (i_Return),
		.i_StoreReady   (i_StoreReady),
		.o_ReadIndex    (readIndex),
		.o_LookupTag    (lookupTag),
		.o_Way          (way),
		.o_WordSel      (wordSel),
		.o_WordWrite    (wordWrite),
		.o_WriteWord    (writeWord),
		.o_RefillWrite  (refillWrite),
		.o_TagFill      (tagFill),
		.o_DataOK       (o_DataOK),
		.o_LoadData     (o_LoadData),
		.o_LoadRequire  (o_LoadRequire),
		.o_LoadAddr     (o_LoadAddr),
		.o_StoreRequire (o_StoreRequire),
		.o_StoreAddr    (o_StoreAddr),
		.o_StoreData    (o_StoreData)
	);

	tagStore uTags (
		.clk           (clk),
		.rstn          (rstn),
		.i_ReadIndex   (readIndex),
		.i_LookupTag   (lookupTag),
		.i_Way         (way),
		.i_WordWrite   (wordWrite),  // sets dirty
		.i_TagFill     (tagFill),    // sets valid
		.o_Hit         (hit),
		.o_HitWay      (hitWay),
		.o_VictimWay   (victimWay),
		.o_VictimDirty (victimDirty),
		.o_VictimTag   (victimTag)
	);

	dataStore uData (
		.clk           (clk),
		.i_ReadIndex   (readIndex),
		.i_Way         (way),
		.i_WordSel     (wordSel),
		.i_WordWrite   (wordWrite),
		.i_WriteWord   (writeWord),
		.i_Refill      (i_Return),   // bus words go straight in
		.i_RefillWrite (refillWrite),
		.o_ReadWord    (readWord),
		.o_VictimLine  (victimLine)
	);

endmodule

//--- rtl/cacheCtrl.sv
// cache controller
// holds one cpu request and sequences lookup, dirty writeback,
// line fetch and refill; answers hits in the lookup cycle

`timescale 1ns/1ps

module cacheCtrl (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            i_Valid,        // cpu request valid
	input  cachePkg::cpuReqT                i_Req,
	input  logic                            i_Hit,
	input  logic                            i_HitWay,
	input  logic                            i_VictimWay,
	input  logic                            i_VictimDirty,
	input  logic [cachePkg::tagBits-1:0]     i_VictimTag,
	input  logic [cachePkg::wordBits-1:0]    i_ReadWord,
	input  cachePkg::lineT                  i_VictimLine,
	input  logic                            i_LoadReady,    // bus took line fetch
	input  cachePkg::refillT                i_Return,
	input  logic                            i_StoreReady,   // bus took writeback
	output logic [cachePkg::indexBits-1:0]   o_ReadIndex,
	output logic [cachePkg::tagBits-1:0]     o_LookupTag,
	output logic                            o_Way,
	output logic [cachePkg::wordSelBits-1:0] o_WordSel,
	output logic                            o_WordWrite,
	output logic [cachePkg::wordBits-1:0]    o_WriteWord,
	output logic                            o_RefillWrite,
	output logic                            o_TagFill,
	output logic                            o_DataOK,
	output logic [cachePkg::wordBits-1:0]    o_LoadData,
	output logic                            o_LoadRequire,
	output logic [cachePkg::addrBits-1:0]    o_LoadAddr,
	output logic                            o_StoreRequire,
	output logic [cachePkg::addrBits-1:0]    o_StoreAddr,
	output cachePkg::lineT                  o_StoreData
);
	import cachePkg::*;

	cacheStateT state;
	cacheStateT nextState;
	cpuReqT     reqQ;          // held cpu request
	logic       victimWayQ;    // way being replaced
	logic       victimDirtyQ;  // victim needs writeback
	cacheAddrT  storeAddrQ;    // line address of victim
	cacheAddrT  victimAddr;
	cacheAddrT  loadAddr;
	logic       lastWord;      // final refill beat
	logic       takeReq;
	logic       missSeen;

	assign takeReq  = (state == idle) & i_Valid;
	assign missSeen = (state == lookup) & ~i_Hit;
	assign lastWord = i_Return.valid
		& (i_Return.offset == wordSelBits'(wordsPerLine - 1));

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= idle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state; // bus stalls just hold
		case (state)
			idle: begin
				if (i_Valid) begin
					nextState = lookup;
				end
			end
			lookup: begin
				nextState = i_Hit ? idle : miss; // one request at a time
			end
			miss: begin
				if (!victimDirtyQ || i_StoreReady) begin
					nextState = replace; // clean victim skips writeback
				end
			end
			replace: begin
				if (i_LoadReady) begin
					nextState = refill;
				end
			end
			refill: begin
				if (lastWord) begin
					nextState = lookup; // retry now hits
				end
			end
			default: nextState = idle;
		endcase
	end

	// request payload, captured once per request
	always_ff @(posedge clk) begin
		if (takeReq) begin
			reqQ <= i_Req;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			victimWayQ   <= 1'b0;
			victimDirtyQ <= 1'b0;
		end else if (missSeen) begin
			victimWayQ   <= i_VictimWay;
			victimDirtyQ <= i_VictimDirty;
		end
	end

	// victim line address from stored tag and held index
	always_comb begin
		victimAddr.fields.tag    = i_VictimTag;
		victimAddr.fields.index  = reqQ.addr.fields.index;
		victimAddr.fields.offset = '0;
	end

	always_ff @(posedge clk) begin
		if (missSeen) begin
			storeAddrQ <= victimAddr;
		end
	end

	// line-aligned fetch address
	always_comb begin
		loadAddr.fields.tag    = reqQ.addr.fields.tag;
		loadAddr.fields.index  = reqQ.addr.fields.index;
		loadAddr.fields.offset = '0;
	end

	// incoming index in idle, held index otherwise
	assign o_ReadIndex = (state == idle) ? i_Req.addr.fields.index
		: reqQ.addr.fields.index;
	assign o_LookupTag = reqQ.addr.fields.tag;
	assign o_Way       = (state == lookup) ? i_HitWay : victimWayQ;
	assign o_WordSel   = reqQ.addr.fields.offset[offsetBits-1 -: wordSelBits];

	// store hit goes straight into the hit way
	assign o_WordWrite   = (state == lookup) & i_Hit & reqQ.write;
	assign o_WriteWord   = reqQ.storeData;
	assign o_RefillWrite = (state == refill) & i_Return.valid;
	assign o_TagFill     = (state == refill) & lastWord;

	assign o_DataOK   = (state == lookup) & i_Hit; // single cycle pulse
	assign o_LoadData = i_ReadWord;

	assign o_LoadRequire  = (state == replace);
	assign o_LoadAddr     = loadAddr.raw;
	assign o_StoreRequire = (state == miss) & victimDirtyQ;
	assign o_StoreAddr    = storeAddrQ.raw;
	assign o_StoreData    = i_VictimLine; // stable while in miss

endmodule

//--- rtl/dataStore.sv
// data store
// four word banks per way, read through a registered index;
// takes word writes from store hits and refill words from the bus
// and returns one word or the whole line of the selected way

`timescale 1ns/1ps

module dataStore (
	input  logic                            clk,
	input  logic [cachePkg::indexBits-1:0]   i_ReadIndex,   // set for read and write
	input  logic                            i_Way,         // hit way or victim way
	input  logic [cachePkg::wordSelBits-1:0] i_WordSel,     // word of held request
	input  logic                            i_WordWrite,   // store hit strobe
	input  logic [cachePkg::wordBits-1:0]    i_WriteWord,
	input  cachePkg::refillT                i_Refill,      // bus return word
	input  logic                            i_RefillWrite, // refill strobe
	output logic [cachePkg::wordBits-1:0]    o_ReadWord,
	output cachePkg::lineT                  o_VictimLine
);
	import cachePkg::*;

	// bank memory, no reset
	logic [wordBits-1:0]    bankMem [numWays][wordsPerLine][numSets];
	logic [indexBits-1:0]   rdIdx;   // sync read address
	logic                   wrEn;
	logic [wordSelBits-1:0] wrSel;   // target bank
	logic [wordBits-1:0]    wrData;
	lineT                   wayLine; // all banks of i_Way

	always_ff @(posedge clk) begin
		rdIdx <= i_ReadIndex;
	end

	// refill and store hit never overlap
	assign wrEn   = i_RefillWrite | i_WordWrite;
	assign wrSel  = i_RefillWrite ? i_Refill.offset : i_WordSel;
	assign wrData = i_RefillWrite ? i_Refill.data : i_WriteWord;

	always_ff @(posedge clk) begin
		if (wrEn) begin
			bankMem[i_Way][wrSel][i_ReadIndex] <= wrData;
		end
	end

	// gather the line of the selected way
	always_comb begin
		for (int b = 0; b < wordsPerLine; b++) begin
			wayLine[b] = bankMem[i_Way][b][rdIdx];
		end
	end

	assign o_ReadWord   = wayLine[i_WordSel]; // load result
	assign o_VictimLine = wayLine;            // writeback data

endmodule

//--- rtl/tagStore.sv
// tag store
// tags, valid, dirty and round-robin bits for both ways,
// read through a registered index; gives hit and victim choice

`timescale 1ns/1ps

module tagStore (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic [cachePkg::indexBits-1:0] i_ReadIndex,  // set to read and write
	input  logic [cachePkg::tagBits-1:0]   i_LookupTag,  // tag of held request
	input  logic                          i_Way,        // way for updates
	input  logic                          i_WordWrite,  // store hit marks dirty
	input  logic                          i_TagFill,    // last refill word
	output logic                          o_Hit,
	output logic                          o_HitWay,
	output logic                          o_VictimWay,
	output logic                          o_VictimDirty,
	output logic [cachePkg::tagBits-1:0]   o_VictimTag
);
	import cachePkg::*;

	logic [tagBits-1:0]                tagArr [numWays][numSets]; // tag memory
	logic [numWays-1:0][numSets-1:0]   validBits;
	logic [numWays-1:0][numSets-1:0]   dirtyBits;
	logic [numSets-1:0]                rrBits;     // per-set round robin
	logic [indexBits-1:0]              rdIdx;      // sync read address
	logic [numWays-1:0]                hitVec;
	logic                              victimWay;

	always_ff @(posedge clk) begin
		rdIdx <= i_ReadIndex; // read lands next cycle
	end

	// tag written only on fill
	always_ff @(posedge clk) begin
		if (i_TagFill) begin
			tagArr[i_Way][i_ReadIndex] <= i_LookupTag;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			validBits <= '0;
			dirtyBits <= '0;
			rrBits    <= '0;
		end else if (i_TagFill) begin
			validBits[i_Way][i_ReadIndex] <= 1'b1;
			dirtyBits[i_Way][i_ReadIndex] <= 1'b0;           // fresh line is clean
			rrBits[i_ReadIndex]           <= ~rrBits[i_ReadIndex]; // next victim
		end else if (i_WordWrite) begin
			dirtyBits[i_Way][i_ReadIndex] <= 1'b1;
		end
	end

	// compare both ways
	always_comb begin
		for (int w = 0; w < numWays; w++) begin
			hitVec[w] = validBits[w][rdIdx] & (tagArr[w][rdIdx] == i_LookupTag);
		end
	end

	assign o_Hit    = |hitVec;
	assign o_HitWay = hitVec[1]; // way 0 unless way 1 matches

	// lowest invalid way wins, else round robin
	always_comb begin
		victimWay = rrBits[rdIdx];
		for (int w = numWays - 1; w >= 0; w--) begin
			if (!validBits[w][rdIdx]) begin
				victimWay = 1'(w);
			end
		end
	end

	assign o_VictimWay   = victimWay;
	assign o_VictimDirty = validBits[victimWay][rdIdx] & dirtyBits[victimWay][rdIdx];
	assign o_VictimTag   = tagArr[victimWay][rdIdx]; // for writeback address

endmodule

//--- rtl/cachePkg.sv
// cache package
// geometry of the two-way write-back data cache and the types
// shared by the controller, tag store, data store and bus side

package cachePkg;

	// address split
	localparam int addrBits     = 32;                  // cpu and bus address
	localparam int wordBits     = 32;                  // one data word
	localparam int tagBits      = 20;                  // addr[31:12]
	localparam int indexBits    = 8;                   // addr[11:4]
	localparam int offsetBits   = 4;                   // addr[3:0] byte offset
	localparam int wordsPerLine = 4;
	localparam int wordSelBits  = $clog2(wordsPerLine); // word select in a line
	localparam int numSets      = 1 << indexBits;
	localparam int numWays      = 2;

	// field view of an address
	typedef struct packed {
		logic [tagBits-1:0]    tag;
		logic [indexBits-1:0]  index;
		logic [offsetBits-1:0] offset; // bits 3:2 pick the word
	} addrFieldsT;

	// one address word seen flat or split
	typedef union packed {
		logic [addrBits-1:0] raw;    // bus address
		addrFieldsT          fields; // tag/index/offset
	} cacheAddrT;

	// cpu request, 65 bits
	typedef struct packed {
		logic                write;     // 1 store, 0 load
		cacheAddrT           addr;
		logic [wordBits-1:0] storeData; // aligned word
	} cpuReqT;

	// whole cache line, word 0 lowest
	typedef logic [wordsPerLine-1:0][wordBits-1:0] lineT;

	// one returned bus word
	typedef struct packed {
		logic                   valid;
		logic [wordSelBits-1:0] offset; // last word ends refill
		logic [wordBits-1:0]    data;
	} refillT;

	// controller states
	typedef enum logic [2:0] {
		idle    = 3'b000,
		lookup  = 3'b001,
		miss    = 3'b011,
		replace = 3'b010,
		refill  = 3'b110
	} cacheStateT;

endpackage
